// ==== tetris_ai_top.f ====
+incdir+.
hw/tetris_ai_pkg.sv
hw/ai_sequencer.sv
hw/ai_move_decode.sv
hw/ai_place_eval.sv
hw/ai_best_select.sv
hw/tetris_ai_top.sv
dv/tetris_ai_tb.sv

// ==== Makefile ====
# Verilator flow for the move evaluator testbench

TOP = tetris_ai_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
	  -f tetris_ai_top.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee run.log
	@if grep -q "CHECKS FAILED" run.log; then \
	  echo "Simulation failed"; \
	  exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" run.log; then \
	  echo "Simulation ended without a result"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir run.log

// ==== dv/tetris_ai_tb.sv ====
`timescale 1ns/1ps
`include "tetris_ai_defines.svh"

module tetris_ai_tb;

  localparam int DONE_LAT    = 44;                 // Accept edge to done edge
  localparam int WATCHDOG_NS = 60 * 50 * 40;       // Searches x cycles x period

  logic                    clk;
  logic                    arst_n;
  logic                    start;
  tetris_ai_pkg::board_t   board;
  tetris_ai_pkg::piece_t   piece_type;
  logic                    busy;
  logic                    done;
  logic                    best_valid;
  tetris_ai_pkg::move_id_t best_move_id;
  tetris_ai_pkg::q_value_t best_q_value;

  int   seed       = 32'h8019;
  int   errors     = 0;
  int   searches   = 0;          // Starts taken by the DUT
  int   launched   = 0;          // Starts issued by stimulus
  int   cyc        = 0;
  int   accept_cyc = 0;
  logic started    = 1'b0;
  logic holding    = 1'b0;       // Between done and next accept
  logic exp_valid  = 1'b0;       // Model result for the pending start
  int   exp_id     = 0;
  int   exp_q      = 0;
  logic chk_valid  = 1'b0;       // Model result of the running search
  int   chk_id     = 0;
  int   chk_q      = 0;

  tetris_ai_top u_tetris_ai_top (
    .clk(clk), .arst_n(arst_n), .start(start), .board(board), .piece_type(piece_type),
    .busy(busy), .done(done), .best_valid(best_valid),
    .best_move_id(best_move_id), .best_q_value(best_q_value)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // A start counts as taken only while busy is low
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (arst_n && start && !busy) begin
      accept_cyc <= cyc;
      started    <= 1'b1;
      holding    <= 1'b0;
      chk_valid  <= exp_valid;
      chk_id     <= exp_id;
      chk_q      <= exp_q;
      searches   <= searches + 1;
    end else if (arst_n && done) begin
      holding <= 1'b1;
    end
  end

  task automatic value_error(input string sig, input longint expv, input longint actv);
    $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, sig, expv, actv);
    errors++;
  endtask

  // ============================================================
  // Port checks
  // ============================================================
  idle_busy : assert property (@(posedge clk) disable iff (!arst_n)
    !started |-> !busy) else value_error("busy", 0, $sampled(busy));
  idle_done : assert property (@(posedge clk) disable iff (!arst_n)
    !started |-> !done) else value_error("done", 0, $sampled(done));
  idle_best : assert property (@(posedge clk) disable iff (!arst_n)
    !started |-> !best_valid) else value_error("best_valid", 0, $sampled(best_valid));

  // Done exactly DONE_LAT edges after accept and never elsewhere
  done_on_time : assert property (@(posedge clk) disable iff (!arst_n)
    done |-> (started && cyc == accept_cyc + DONE_LAT)) else value_error("done", 0, 1);
  done_present : assert property (@(posedge clk) disable iff (!arst_n)
    (started && cyc == accept_cyc + DONE_LAT) |-> done)
    else value_error("done", 1, $sampled(done));

  busy_window : assert property (@(posedge clk) disable iff (!arst_n)
    (started && cyc > accept_cyc && cyc <= accept_cyc + DONE_LAT) |-> busy)
    else value_error("busy", 1, $sampled(busy));
  busy_release : assert property (@(posedge clk) disable iff (!arst_n)
    (started && cyc == accept_cyc + DONE_LAT + 1) |-> !busy)
    else value_error("busy", 0, $sampled(busy));

  // Results at done and held afterwards
  best_valid_ok : assert property (@(posedge clk) disable iff (!arst_n)
    (done || holding) |-> (best_valid == chk_valid))
    else value_error("best_valid", $sampled(chk_valid), $sampled(best_valid));
  best_id_ok : assert property (@(posedge clk) disable iff (!arst_n)
    ((done || holding) && chk_valid) |-> (best_move_id == chk_id))
    else value_error("best_move_id", $sampled(chk_id), $sampled(best_move_id));
  best_q_ok : assert property (@(posedge clk) disable iff (!arst_n)
    ((done || holding) && chk_valid) |-> (best_q_value == chk_q))
    else value_error("best_q_value", $sampled(chk_q), $sampled(best_q_value));

  // ============================================================
  // Reference model
  // ============================================================
  // Spawn pictures with row 0 in [7:4] and column 0 at the MSB
  function automatic logic [7:0] spawn_mask(input int p);
    case (p)
      0:       return 8'b1111_0000;   // I
      1:       return 8'b1100_1100;   // O
      2:       return 8'b0100_1110;   // T
      3:       return 8'b0110_1100;   // S
      4:       return 8'b1100_0110;   // Z
      5:       return 8'b1000_1110;   // J
      default: return 8'b0010_1110;   // L
    endcase
  endfunction

  function automatic int max4(input int v[4]);
    int m;
    m = v[0];
    for (int k = 1; k < 4; k++) begin
      if (v[k] > m) m = v[k];
    end
    return m;
  endfunction

  function automatic bit piece_fits(input tetris_ai_pkg::board_t b, input int cr[4],
                                    input int cc[4], input int y, input int x);
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
      if (y + cr[k] >= `BOARD_ROWS || x + cc[k] >= `BOARD_COLS) ok = 1'b0;
      else if (b[y + cr[k]][x + cc[k]]) ok = 1'b0;
    end
    return ok;
  endfunction

  // Full rows removed one at a time, everything above drops by one
  function automatic int board_score(input tetris_ai_pkg::board_t m);
    tetris_ai_pkg::board_t cl;
    int hgt [`BOARD_COLS];
    int fill;
    int lines;
    int agg;
    int holes;
    int bump;
    int d;
    cl    = m;
    lines = 0;
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      if (&cl[r]) begin
        lines++;
        for (int s = r; s > 0; s--) cl[s] = cl[s-1];
        cl[0] = '0;
      end
    end
    agg   = 0;
    holes = 0;
    for (int c = 0; c < `BOARD_COLS; c++) begin
      hgt[c] = 0;
      fill   = 0;
      for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
        if (cl[r][c]) begin
          hgt[c] = `BOARD_ROWS - r;         // Last hit going up is the top
          fill++;
        end
      end
      agg   += hgt[c];
      holes += hgt[c] - fill;                // Empty cells under the top
    end
    bump = 0;
    for (int c = 1; c < `BOARD_COLS; c++) begin
      d     = hgt[c] - hgt[c-1];
      bump += (d < 0) ? -d : d;
    end
    return `W_LINES * lines - `W_HEIGHT * agg - `W_HOLES * holes - `W_BUMP * bump;
  endfunction

  // Scan of all 40 moves for one board and piece
  function automatic void model_search(input tetris_ai_pkg::board_t b, input int p);
    int         cr [4];
    int         cc [4];
    int         n;
    int         t;
    int         hgt;
    int         w;
    int         y;
    int         sc;
    logic [7:0] mask;
    tetris_ai_pkg::board_t m;
    exp_valid = 1'b0;
    exp_id    = 0;
    exp_q     = 0;
    if (p < `NUM_PIECES) begin
      mask = spawn_mask(p);
      for (int rot = 0; rot < `NUM_ROT; rot++) begin
        n = 0;
        for (int r = 0; r < 2; r++) begin
          for (int c = 0; c < 4; c++) begin
            if (mask[7 - 4 * r - c]) begin
              cr[n] = r;
              cc[n] = c;
              n++;
            end
          end
        end
        for (int q = 0; q < rot; q++) begin   // Clockwise quarter turns
          hgt = max4(cr) + 1;
          for (int k = 0; k < 4; k++) begin
            t     = cr[k];
            cr[k] = cc[k];
            cc[k] = hgt - 1 - t;
          end
        end
        w = max4(cc) + 1;
        for (int col = 0; col < `BOARD_COLS; col++) begin
          if (col + w <= `BOARD_COLS && piece_fits(b, cr, cc, 0, col)) begin
            y = 0;
            while (y < `BOARD_ROWS - 1 && piece_fits(b, cr, cc, y + 1, col)) y++;
            m = b;
            for (int k = 0; k < 4; k++) m[y + cr[k]][col + cc[k]] = 1'b1;
            sc = board_score(m);
            if (!exp_valid || sc > exp_q) begin  // Strict greater keeps lowest id on ties
              exp_valid = 1'b1;
              exp_id    = rot * `BOARD_COLS + col;
              exp_q     = sc;
            end
          end
        end
      end
    end
  endfunction

  // ============================================================
  // Stimulus helpers
  // ============================================================
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Random stacks with the top cell set so gaps below become holes
  function automatic tetris_ai_pkg::board_t random_board();
    tetris_ai_pkg::board_t b;
    int h;
    b = '0;
    for (int c = 0; c < `BOARD_COLS; c++) begin
      h = rand_below(9);
      for (int r = `BOARD_ROWS - h; r < `BOARD_ROWS; r++)
        b[r][c] = (r == `BOARD_ROWS - h) || (rand_below(4) != 0);
    end
    return b;
  endfunction

  // Bottom rows full except one column
  function automatic tetris_ai_pkg::board_t gap_board(input int rows, input int gap_col);
    tetris_ai_pkg::board_t b;
    b = '0;
    for (int r = `BOARD_ROWS - rows; r < `BOARD_ROWS; r++) begin
      b[r]          = '1;
      b[r][gap_col] = 1'b0;
    end
    return b;
  endfunction

  task automatic run_search(input tetris_ai_pkg::board_t b, input tetris_ai_pkg::piece_t p,
                            input bit disturb);
    board      = b;
    piece_type = p;
    model_search(b, int'(p));
    launched++;
    start = 1'b1;
    @(posedge clk);
    #2 start = 1'b0;
    if (disturb) begin
      repeat (5) @(posedge clk);
      #2;
      start      = 1'b1;                     // Must be ignored while busy
      board      = ~b;
      piece_type = (p == 5'd1) ? 5'd0 : 5'd1;
      @(posedge clk);
      #2 start = 1'b0;
    end
    @(posedge clk);
    while (done !== 1'b1) @(posedge clk);
    #2;
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    tetris_ai_pkg::board_t b;
    arst_n     = 1'b0;
    start      = 1'b0;
    board      = '0;
    piece_type = '0;
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;
    repeat (3) @(posedge clk);               // Quiet window after reset
    #2;
    for (int p = 0; p < `NUM_PIECES; p++) run_search('0, 5'(p), 1'b0);
    run_search(gap_board(1, 4), 5'd0, 1'b0); // Line clears
    run_search(gap_board(2, 0), 5'd0, 1'b0);
    run_search(gap_board(2, 9), 5'd6, 1'b0);
    run_search(gap_board(1, 5), 5'd2, 1'b0);
    for (int i = 0; i < 40; i++) begin
      b = random_board();
      run_search(b, 5'(rand_below(`NUM_PIECES)), (i % 8) == 3);
    end
    run_search(gap_board(2, 0), 5'd0, 1'b1);
    run_search('0, 5'd9, 1'b0);              // Not a piece
    b = '1;
    for (int c = 1; c < `BOARD_COLS; c += 2) b[0][c] = 1'b0;
    run_search(b, 5'd3, 1'b0);               // No room anywhere
    repeat (3) @(posedge clk);
    if (searches != launched) begin
      $display("Start count wrong: %0d issued but %0d accepted", launched, searches);
      errors++;
    end
    $display("Summary: %0d searches, %0d errors", searches, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, a search never finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== hw/tetris_ai_top.sv ====
`timescale 1ns/1ps

module tetris_ai_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  tetris_ai_pkg::board_t    board,
  input  tetris_ai_pkg::piece_t    piece_type,
  output logic                     busy,
  output logic                     done,
  output logic                     best_valid,
  output tetris_ai_pkg::move_id_t  best_move_id,
  output tetris_ai_pkg::q_value_t  best_q_value
);

  logic                      start_accept;  // Start seen while idle

  // Sequencer to decode and eval
  tetris_ai_pkg::board_t     board_q;
  tetris_ai_pkg::piece_t     piece_q;
  logic                      id_valid;
  tetris_ai_pkg::move_id_t   move_id;
  logic                      last_issue;

  // Decode to eval
  logic                      req_valid;
  tetris_ai_pkg::move_req_t  req;
  logic                      dec_last;

  // Eval to select
  logic                      res_valid;
  tetris_ai_pkg::eval_res_t  res;
  logic                      eval_last;

  assign start_accept = start && !busy;

  // ============================================================
  // Pipeline
  // ============================================================
  ai_sequencer u_sequencer (
    .clk(clk), .arst_n(arst_n),
    .start(start), .board(board), .piece_type(piece_type),
    .busy(busy), .board_q(board_q), .piece_q(piece_q),
    .id_valid(id_valid), .move_id(move_id), .last_issue(last_issue),
    .done(done)
  );

  ai_move_decode u_decode (
    .clk(clk), .arst_n(arst_n),
    .id_valid(id_valid), .move_id(move_id), .last_in(last_issue), .piece(piece_q),
    .req_valid(req_valid), .req(req), .last_out(dec_last)
  );

  ai_place_eval u_eval (
    .clk(clk), .arst_n(arst_n),
    .req_valid(req_valid), .req(req), .last_in(dec_last), .board(board_q),
    .res_valid(res_valid), .res(res), .last_out(eval_last)
  );

  ai_best_select u_select (
    .clk(clk), .arst_n(arst_n),
    .res_valid(res_valid), .res(res), .last_in(eval_last),
    .start_accept(start_accept),
    .best_valid(best_valid), .best_move_id(best_move_id),
    .best_q_value(best_q_value), .done(done)
  );

endmodule

// ==== hw/ai_best_select.sv ====
`timescale 1ns/1ps

module ai_best_select (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       res_valid,
  input  tetris_ai_pkg::eval_res_t   res,
  input  logic                       last_in,
  input  logic                       start_accept,
  output logic                       best_valid,
  output tetris_ai_pkg::move_id_t    best_move_id,
  output tetris_ai_pkg::q_value_t    best_q_value,
  output logic                       done
);

  logic take;

  // Strictly greater only, so ties keep the earlier and lower id
  assign take = res_valid && res.legal &&
                (!best_valid || (res.q_value > best_q_value));

  // ============================================================
  // Running best
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      best_valid   <= 1'b0;
      best_move_id <= '0;
      best_q_value <= '0;
    end else begin
      if (start_accept) begin
        best_valid   <= 1'b0;       // New search
        best_move_id <= '0;
        best_q_value <= '0;
      end else if (take) begin
        best_valid   <= 1'b1;
        best_move_id <= res.move_id;
        best_q_value <= res.q_value;
      end
    end
  end

  // Done follows the tagged last result by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else begin
      done <= res_valid && last_in;
    end
  end

  // Only one result per search carries the tag
  a_done_pulse : assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !done);

endmodule

// ==== hw/ai_place_eval.sv ====
`timescale 1ns/1ps
`include "tetris_ai_defines.svh"

module ai_place_eval (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      req_valid,
  input  tetris_ai_pkg::move_req_t  req,
  input  logic                      last_in,
  input  tetris_ai_pkg::board_t     board,
  output logic                      res_valid,
  output tetris_ai_pkg::eval_res_t  res,
  output logic                      last_out
);

  // True when every cell of the piece sits inside the board on an empty cell
  function automatic logic fits_at(input tetris_ai_pkg::board_t b,
                                   input tetris_ai_pkg::move_req_t rq,
                                   input int y);
    int  r;
    int  c;
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
      r = y + int'(rq.cell_r[k]);
      c = int'(rq.col) + int'(rq.cell_c[k]);
      if (r >= `BOARD_ROWS || c >= `BOARD_COLS) ok = 1'b0;  // Floor or wall
      else if (b[r][c]) ok = 1'b0;
    end
    return ok;
  endfunction

  // ============================================================
  // Stage 1: drop and merge
  // ============================================================
  logic [`BOARD_ROWS-1:0] fits;
  tetris_ai_pkg::row_t    land;     // Top row of the piece box at rest
  logic                   place_ok;
  tetris_ai_pkg::board_t  merged;

  always_comb begin
    for (int y = 0; y < `BOARD_ROWS; y++) fits[y] = fits_at(board, req, y);
    land = '0;
    for (int y = 1; y < `BOARD_ROWS; y++) begin
      if (fits[y] && (int'(land) == y - 1)) land = 5'(y); // Fall while clear
    end
    place_ok = req.legal && fits[0];  // Spawn collision makes it illegal
    merged   = board;
    if (place_ok) begin
      for (int k = 0; k < 4; k++) begin
        merged[int'(land) + int'(req.cell_r[k])][int'(req.col) + int'(req.cell_c[k])] = 1'b1;
      end
    end
  end

  logic                    s1_valid;
  logic                    s1_last;
  logic                    s1_legal;
  tetris_ai_pkg::move_id_t s1_move_id;
  tetris_ai_pkg::board_t   s1_board;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= req_valid;
      s1_last  <= req_valid && last_in;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      s1_legal   <= place_ok;
      s1_move_id <= req.move_id;
      s1_board   <= merged;
    end
  end

  // ============================================================
  // Stage 2: clear rows, features, weighted score
  // ============================================================
  tetris_ai_pkg::board_t   cleared;
  int                      wr;          // Next row to fill, from the bottom
  int                      lines_c;
  int                      heights [`BOARD_COLS];
  int                      agg_c;
  int                      holes_c;
  int                      bump_c;
  int                      score_c;
  logic                    seen;
  tetris_ai_pkg::q_value_t score_q;

  always_comb begin
    cleared = '0;
    wr      = `BOARD_ROWS - 1;
    lines_c = 0;
    for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
      if (&s1_board[r]) lines_c = lines_c + 1;      // Full row drops out
      else begin
        cleared[wr] = s1_board[r];                  // Survivors shift down
        wr = wr - 1;
      end
    end
    agg_c   = 0;
    holes_c = 0;
    for (int c = 0; c < `BOARD_COLS; c++) begin
      heights[c] = 0;
      seen       = 1'b0;
      for (int r = 0; r < `BOARD_ROWS; r++) begin
        if (cleared[r][c]) begin
          if (!seen) heights[c] = `BOARD_ROWS - r;  // Topmost filled cell
          seen = 1'b1;
        end else if (seen) begin
          holes_c = holes_c + 1;                    // Covered empty cell
        end
      end
      agg_c = agg_c + heights[c];
    end
    bump_c = 0;
    for (int c = 0; c < `BOARD_COLS - 1; c++) begin
      if (heights[c] > heights[c+1]) bump_c = bump_c + heights[c] - heights[c+1];
      else                           bump_c = bump_c + heights[c+1] - heights[c];
    end
    score_c = `W_LINES * lines_c - `W_HEIGHT * agg_c
            - `W_HOLES * holes_c - `W_BUMP * bump_c;
    score_q = score_c[`Q_W-1:0];                    // Range fits 18 bits signed
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      res_valid <= s1_valid;
      last_out  <= s1_valid && s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res.move_id <= s1_move_id;
      res.q_value <= s1_legal ? score_q : '0;       // Illegal moves carry zero
      res.legal   <= s1_legal;
    end
  end

  // Payload registers are loaded in the same cycle valid is raised
  a_res_known : assert property (@(posedge clk) disable iff (!arst_n)
    res_valid |-> !$isunknown(res));

endmodule

// ==== hw/ai_move_decode.sv ====
`timescale 1ns/1ps
`include "tetris_ai_defines.svh"

module ai_move_decode (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       id_valid,
  input  tetris_ai_pkg::move_id_t    move_id,
  input  logic                       last_in,
  input  tetris_ai_pkg::piece_t      piece,
  output logic                       req_valid,
  output tetris_ai_pkg::move_req_t   req,
  output logic                       last_out
);

  logic [1:0]          rot;
  tetris_ai_pkg::col_t col;
  logic [3:0][3:0]     cells;   // Per cell nibble {row, col}, cell 3 leftmost
  logic [2:0]          width;
  logic                known;

  // Split id into rotation and column, compares against 10, 20, 30
  always_comb begin
    rot = 2'd0;
    col = move_id[3:0];
    for (int r = 1; r < `NUM_ROT; r++) begin
      if (move_id >= `MOVE_ID_W'(r * `BOARD_COLS)) begin
        rot = r[1:0];
        col = 4'(move_id - `MOVE_ID_W'(r * `BOARD_COLS));
      end
    end
  end

  // ============================================================
  // Shape table, clockwise turns renormalized to top left
  // ============================================================
  always_comb begin
    known = (piece < 5'(`NUM_PIECES));
    cells = 16'h0000;
    width = 3'd1;
    case (piece)
      5'd0: begin                                   // I
        if (rot[0]) begin cells = 16'hC840; width = 3'd1; end // Vertical
        else        begin cells = 16'h3210; width = 3'd4; end
      end
      5'd1: begin cells = 16'h5410; width = 3'd2; end // O, all rotations alike
      5'd2: begin                                   // T
        case (rot)
          2'd0:    begin cells = 16'h6541; width = 3'd3; end // .X. / XXX
          2'd1:    begin cells = 16'h8540; width = 3'd2; end // Points right
          2'd2:    begin cells = 16'h5210; width = 3'd3; end // XXX / .X.
          default: begin cells = 16'h9541; width = 3'd2; end // Points left
        endcase
      end
      5'd3: begin                                   // S, two distinct shapes
        if (rot[0]) begin cells = 16'h9540; width = 3'd2; end
        else        begin cells = 16'h5421; width = 3'd3; end
      end
      5'd4: begin                                   // Z
        if (rot[0]) begin cells = 16'h8541; width = 3'd2; end
        else        begin cells = 16'h6510; width = 3'd3; end
      end
      5'd5: begin                                   // J
        case (rot)
          2'd0:    begin cells = 16'h6540; width = 3'd3; end // X.. / XXX
          2'd1:    begin cells = 16'h8410; width = 3'd2; end
          2'd2:    begin cells = 16'h6210; width = 3'd3; end
          default: begin cells = 16'h9851; width = 3'd2; end
        endcase
      end
      5'd6: begin                                   // L
        case (rot)
          2'd0:    begin cells = 16'h6542; width = 3'd3; end // ..X / XXX
          2'd1:    begin cells = 16'h9840; width = 3'd2; end
          2'd2:    begin cells = 16'h4210; width = 3'd3; end
          default: begin cells = 16'h9510; width = 3'd2; end
        endcase
      end
      default: ;                                    // Not a piece, flagged below
    endcase
  end

  // ============================================================
  // Output register
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      req_valid <= id_valid;
      last_out  <= id_valid && last_in;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid) begin
      req.move_id <= move_id;
      req.rot     <= rot;
      req.col     <= col;
      for (int k = 0; k < 4; k++) begin
        req.cell_r[k] <= cells[k][3:2];
        req.cell_c[k] <= cells[k][1:0];
      end
      req.width   <= width;
      req.legal   <= known && ((5'(col) + 5'(width)) <= 5'(`BOARD_COLS)); // Right wall
    end
  end

endmodule

// ==== hw/ai_sequencer.sv ====
`timescale 1ns/1ps
`include "tetris_ai_defines.svh"

module ai_sequencer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,
  input  tetris_ai_pkg::board_t  board,
  input  tetris_ai_pkg::piece_t  piece_type,
  output logic                   busy,
  output tetris_ai_pkg::board_t  board_q,
  output tetris_ai_pkg::piece_t  piece_q,
  output logic                   id_valid,
  output tetris_ai_pkg::move_id_t move_id,
  output logic                   last_issue,
  input  logic                   done
);

  tetris_ai_pkg::seq_state_e state;
  tetris_ai_pkg::move_id_t   cnt;    // Next id to issue
  logic                      accept;

  assign accept = start && (state == tetris_ai_pkg::IDLE);

  // ============================================================
  // Control FSM
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= tetris_ai_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        tetris_ai_pkg::IDLE: begin
          if (accept) begin
            state <= tetris_ai_pkg::ISSUE;
            cnt   <= '0;
          end
        end
        tetris_ai_pkg::ISSUE: begin
          cnt <= cnt + 1'b1;                    // One id per cycle
          if (last_issue) state <= tetris_ai_pkg::DRAIN;
        end
        tetris_ai_pkg::DRAIN: begin
          if (done) state <= tetris_ai_pkg::IDLE; // Pipeline emptied
        end
        default: state <= tetris_ai_pkg::IDLE;
      endcase
    end
  end

  // Snapshot of the inputs, frozen for the whole search
  always_ff @(posedge clk) begin
    if (accept) begin
      board_q <= board;
      piece_q <= piece_type;
    end
  end

  assign busy       = (state != tetris_ai_pkg::IDLE);
  assign id_valid   = (state == tetris_ai_pkg::ISSUE);
  assign move_id    = cnt;
  assign last_issue = id_valid && (cnt == `MOVE_ID_W'(`NUM_MOVES - 1)); // Tag for id 39

  // Counter never leaves the move space while issuing
  a_id_range : assert property (@(posedge clk) disable iff (!arst_n)
    id_valid |-> (move_id < `MOVE_ID_W'(`NUM_MOVES)));

endmodule

// ==== hw/tetris_ai_pkg.sv ====
`include "tetris_ai_defines.svh"

package tetris_ai_pkg;

  // ============================================================
  // Vector types
  // ============================================================
  typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board_t; // [row][col], row 0 on top
  typedef logic [4:0]                   piece_t;    // I=0 O=1 T=2 S=3 Z=4 J=5 L=6
  typedef logic [`MOVE_ID_W-1:0]        move_id_t;  // rot*10 + col
  typedef logic signed [`Q_W-1:0]       q_value_t;
  typedef logic [3:0]                   col_t;
  typedef logic [4:0]                   row_t;

  // ============================================================
  // Stage payloads
  // ============================================================

  // Decode to execute
  typedef struct packed {
    move_id_t         move_id;
    logic [1:0]       rot;
    col_t             col;     // Leftmost column of the piece box
    logic [3:0][1:0]  cell_r;  // Row offsets inside the box
    logic [3:0][1:0]  cell_c;  // Column offsets inside the box
    logic [2:0]       width;   // 1 to 4
    logic             legal;   // Known piece, fits horizontally
  } move_req_t;

  // Execute to result
  typedef struct packed {
    move_id_t  move_id;
    q_value_t  q_value;
    logic      legal;          // Also covers spawn collision
  } eval_res_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } seq_state_e;

endpackage

// ==== tetris_ai_defines.svh ====
`ifndef TETRIS_AI_DEFINES_SVH
`define TETRIS_AI_DEFINES_SVH

// ============================================================
// Board geometry
// ============================================================
`define BOARD_ROWS 20   // Row 0 at the top
`define BOARD_COLS 10

// Move space, 4 rotations by 10 leftmost columns
`define NUM_MOVES  40
`define NUM_ROT    4
`define NUM_PIECES 7    // I O T S Z J L

// Field widths
`define MOVE_ID_W  6
`define Q_W        18   // Signed score

// ============================================================
// Heuristic weights, integer
// ============================================================
`define W_LINES    76   // Reward per cleared row
`define W_HEIGHT   51   // Penalty per unit of aggregate height
`define W_HOLES    36   // Penalty per covered empty cell
`define W_BUMP     18   // Penalty per unit of surface roughness

`endif
